//--- dv/executeStageAssert.sv
`timescale 1ns/1ps
`default_nettype none

module executeStageAssert import PipelineTypes::*; (
  input logic clk,
  input logic rstN,
  input MemoryAccessStagePipeReg nextStage,
  input RedirectReq redirect
);

  // reset masks every control bit of the next cycle
  resetClears: assert property (@(posedge clk) !rstN |=>
    !(nextStage.rdCtrl.wEn || nextStage.isLoad || nextStage.isStore || redirect.taken))
    else $error("control bits not cleared after a reset cycle");

  // a taken redirect never comes from a memory access
  takenNotMemory: assert property (@(posedge clk)
    redirect.taken |-> !(nextStage.isLoad || nextStage.isStore))
    else $error("redirect taken for a load or store record");

  loadStoreExclusive: assert property (@(posedge clk) !(nextStage.isLoad && nextStage.isStore))
    else $error("load and store both set in the EX/MEM register");

endmodule

bind executeStage executeStageAssert executeStageAssertInst (
  .clk(clk),
  .rstN(rstN),
  .nextStage(nextStage),
  .redirect(redirect)
);

`default_nettype wire

//--- dv/tbExecuteStage.sv
`timescale 1ns/1ps
`default_nettype none

module tbExecuteStage import PipelineTypes::*; ();

  localparam int NumRecords = 400;

  typedef struct packed {
    DecodeStagePipeReg prev;
    BasicData exData;
    BasicData memData;
  } Stimulus;

  typedef struct packed {
    MemoryAccessStagePipeReg ms;
    RedirectReq rd;
  } Expected;

  logic clk;
  logic rstN;
  DecodeStagePipeReg prev;
  BasicData bypassExData;
  BasicData bypassMemData;
  MemoryAccessStagePipeReg nextStage;
  RedirectReq redirect;
  BasicData exwData;
  RdCtrl rdCtrl;

  Stimulus pending[$];
  int errorCount = 0;
  int checkedCount = 0;

  executeStage executeStage_inst (
    .clk(clk),
    .rstN(rstN),
    .prev(prev),
    .bypassExData(bypassExData),
    .bypassMemData(bypassMemData),
    .nextStage(nextStage),
    .redirect(redirect),
    .exwData(exwData),
    .rdCtrl(rdCtrl)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (actVal !== expVal) begin
      errorCount++;
      $display("[FAIL] %s expected %h actual %h", name, expVal, actVal);
    end
  endtask

  task automatic checkControlsClear();
    checkValue("nextStage.rdCtrl.wEn", 32'd0, 32'(nextStage.rdCtrl.wEn));
    checkValue("nextStage.isLoad", 32'd0, 32'(nextStage.isLoad));
    checkValue("nextStage.isStore", 32'd0, 32'(nextStage.isStore));
    checkValue("redirect.taken", 32'd0, 32'(redirect.taken));
  endtask

  function automatic BasicData pickSource(input BypassCtrl sel, input BasicData regVal,
                                          input Stimulus s);
    if (sel == BYPASS_EXEC) return s.exData;
    if (sel == BYPASS_MEM) return s.memData;
    return regVal;
  endfunction

  // expected EX/MEM and redirect contents for one record
  function automatic Expected predict(input Stimulus s);
    Expected e;
    BasicData rs1;
    BasicData rs2;
    BasicData a;
    BasicData b;
    BasicData base;
    logic isBr;
    logic cond;
    rs1 = pickSource(s.prev.op1BypassCtrl, s.prev.rs1Data, s);
    rs2 = pickSource(s.prev.op2BypassCtrl, s.prev.rs2Data, s);
    a = (s.prev.aluCtrl.op1Sel == OP1_PC) ? s.prev.pc :
        (s.prev.aluCtrl.op1Sel == OP1_ZERO) ? 32'd0 : rs1;
    b = (s.prev.aluCtrl.op2Sel == OP2_IMM) ? s.prev.imm :
        (s.prev.aluCtrl.op2Sel == OP2_FOUR) ? 32'd4 : rs2;
    e = '0;
    e.ms.pc = s.prev.pc;
    e.ms.wData = rs2;
    e.ms.memAccessWidth = MEM_WORD;
    e.ms.rdCtrl = s.prev.rdCtrl;
    e.ms.isStore = s.prev.isStore;
    e.ms.isLoad = s.prev.isLoad;
    isBr = 1'b1;
    cond = 1'b1;
    case (s.prev.aluCtrl.aluCode)
      ADD: e.ms.aluResult = a + b;
      SUB: e.ms.aluResult = a - b;
      SLL: e.ms.aluResult = a << b[4:0];
      SLT: e.ms.aluResult = 32'($signed(a) < $signed(b));
      SLTU: e.ms.aluResult = 32'(a < b);
      XOR: e.ms.aluResult = a ^ b;
      SRL: e.ms.aluResult = a >> b[4:0];
      SRA: e.ms.aluResult = $unsigned($signed(a) >>> b[4:0]);
      OR: e.ms.aluResult = a | b;
      AND: e.ms.aluResult = a & b;
      LUI: e.ms.aluResult = b;
      JAL, JALR: e.ms.aluResult = a + b;
      BEQ: cond = (a == b);
      BNE: cond = (a != b);
      BLT: cond = ($signed(a) < $signed(b));
      BGE: cond = ($signed(a) >= $signed(b));
      BLTU: cond = (a < b);
      BGEU: cond = (a >= b);
      default: e.ms.aluResult = a + b; // loads and stores
    endcase
    if (s.prev.aluCtrl.aluCode inside {LB, LBU, SB}) e.ms.memAccessWidth = MEM_BYTE;
    if (s.prev.aluCtrl.aluCode inside {LH, LHU, SH}) e.ms.memAccessWidth = MEM_HALF;
    e.ms.isLoadUnsigned = s.prev.aluCtrl.aluCode inside {LBU, LHU};
    if (!(s.prev.aluCtrl.aluCode inside {JAL, JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU})) begin
      isBr = 1'b0;
    end
    base = (s.prev.aluCtrl.aluCode == JALR) ? rs1 : s.prev.pc;
    e.rd.target = (base + s.prev.imm) & 32'hffff_fffe;
    e.rd.taken = isBr & cond;
    return e;
  endfunction

  task automatic makeStimulus(output Stimulus s);
    s = '0;
    s.prev.pc = {30'($urandom_range(0, 32'h3fff_ffff)), 2'b00};
    s.prev.rs1Data = $urandom;
    s.prev.rs2Data = $urandom;
    s.prev.imm = $urandom;
    s.exData = $urandom;
    s.memData = $urandom;
    s.prev.op1BypassCtrl = BypassCtrl'(2'($urandom_range(0, 2)));
    s.prev.op2BypassCtrl = BypassCtrl'(2'($urandom_range(0, 2)));
    if ($urandom_range(0, 3) == 0) begin // equal operands so branches get taken
      s.prev.rs2Data = s.prev.rs1Data;
      s.prev.op2BypassCtrl = s.prev.op1BypassCtrl;
    end
    s.prev.aluCtrl.aluCode = AluCode'(5'($urandom_range(0, 26)));
    s.prev.rdCtrl.wEn = 1'($urandom);
    s.prev.rdCtrl.addr = 5'($urandom);
    case (s.prev.aluCtrl.aluCode)
      LUI: s.prev.aluCtrl.op1Sel = OP1_ZERO;
      JAL, JALR: s.prev.aluCtrl.op1Sel = OP1_PC;
      BEQ, BNE, BLT, BGE, BLTU, BGEU: s.prev.rdCtrl.wEn = 1'b0;
      LB, LH, LW, LBU, LHU: begin
        s.prev.isLoad = 1'b1;
        s.prev.rdCtrl.wEn = 1'b1;
        s.prev.rdCtrl.isLoadData = 1'b1;
      end
      SB, SH, SW: begin
        s.prev.isStore = 1'b1;
        s.prev.rdCtrl.wEn = 1'b0;
      end
      default: begin
        s.prev.aluCtrl.op1Sel = Op1Sel'(2'($urandom_range(0, 2)));
        s.prev.aluCtrl.op2Sel = Op2Sel'(2'($urandom_range(0, 2)));
      end
    endcase
    if (s.prev.aluCtrl.aluCode inside {LUI, LB, LH, LW, LBU, LHU, SB, SH, SW}) begin
      s.prev.aluCtrl.op2Sel = OP2_IMM;
    end
    if (s.prev.aluCtrl.aluCode inside {JAL, JALR}) s.prev.aluCtrl.op2Sel = OP2_FOUR;
  endtask

  initial begin : compareFlow
    Stimulus got;
    Expected exp;
    forever begin
      @(negedge clk);
      if (pending.size() > 0) begin
        got = pending.pop_front();
        exp = predict(got);
        checkValue("nextStage.pc", exp.ms.pc, nextStage.pc);
        checkValue("nextStage.aluResult", exp.ms.aluResult, nextStage.aluResult);
        checkValue("exwData", exp.ms.aluResult, exwData);
        checkValue("nextStage.wData", exp.ms.wData, nextStage.wData);
        checkValue("nextStage.memAccessWidth", 32'(exp.ms.memAccessWidth),
                   32'(nextStage.memAccessWidth));
        checkValue("nextStage.rdCtrl", 32'(exp.ms.rdCtrl), 32'(nextStage.rdCtrl));
        checkValue("nextStage.isStore", 32'(exp.ms.isStore), 32'(nextStage.isStore));
        checkValue("nextStage.isLoad", 32'(exp.ms.isLoad), 32'(nextStage.isLoad));
        checkValue("nextStage.isLoadUnsigned", 32'(exp.ms.isLoadUnsigned),
                   32'(nextStage.isLoadUnsigned));
        checkValue("redirect.taken", 32'(exp.rd.taken), 32'(redirect.taken));
        checkValue("redirect.target", exp.rd.target, redirect.target);
        checkedCount++;
      end
    end
  end

  initial begin : mainFlow
    Stimulus stim;
    int waitCycles;
    void'($urandom(32'h411c16ad));
    rstN = 1'b0;
    prev = '0;
    prev.aluCtrl.aluCode = JAL; // live controls that reset has to mask
    prev.rdCtrl.wEn = 1'b1;
    prev.isLoad = 1'b1;
    prev.isStore = 1'b1;
    bypassExData = '0;
    bypassMemData = '0;
    repeat (5) begin
      @(negedge clk);
      checkControlsClear();
    end
    rstN = 1'b1;
    prev = '0;
    @(negedge clk);
    checkControlsClear(); // bubble registered right after reset
    for (int i = 0; i < NumRecords; i++) begin
      @(negedge clk);
      makeStimulus(stim);
      prev = stim.prev;
      bypassExData = stim.exData;
      bypassMemData = stim.memData;
      @(posedge clk);
      checkValue("rdCtrl", 32'(stim.prev.rdCtrl), 32'(rdCtrl));
      pending.push_back(stim);
    end
    @(negedge clk);
    prev = '0;
    waitCycles = 0;
    while (checkedCount < NumRecords && waitCycles < 20) begin
      @(negedge clk);
      waitCycles++;
    end
    if (checkedCount < NumRecords) begin
      errorCount++;
      $display("timeout: only %0d of %0d records reached the output", checkedCount, NumRecords);
    end
    $display("checked %0d records, %0d errors", checkedCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
rtl/PipelineTypes.sv
rtl/execSwitcher.sv
rtl/alu.sv
rtl/irregPcGen.sv
rtl/executeStage.sv
dv/executeStageAssert.sv
dv/tbExecuteStage.sv

//--- rtl/PipelineTypes.sv
`default_nettype none

package PipelineTypes;

  typedef logic [31:0] BasicData;
  typedef logic [4:0] RegAddr;

  // forwarding source for a source operand
  typedef enum logic [1:0] {
    BYPASS_NONE,
    BYPASS_EXEC, // from EX/MEM
    BYPASS_MEM   // from MEM/WB
  } BypassCtrl;

  typedef enum logic [4:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    LUI,
    JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW
  } AluCode;

  typedef enum logic [1:0] {
    OP1_RS1,
    OP1_PC,
    OP1_ZERO
  } Op1Sel;

  typedef enum logic [1:0] {
    OP2_RS2,
    OP2_IMM,
    OP2_FOUR
  } Op2Sel;

  typedef struct packed {
    AluCode aluCode;
    Op1Sel op1Sel;
    Op2Sel op2Sel;
  } AluCtrl;

  typedef struct packed {
    logic wEn;
    RegAddr addr;
    logic isLoadData; // result comes back from memory
  } RdCtrl;

  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } MemAccessWidth;

  // ID/EX register
  typedef struct packed {
    BasicData pc;
    BasicData rs1Data;
    BasicData rs2Data;
    BasicData imm;
    AluCtrl aluCtrl;
    BypassCtrl op1BypassCtrl;
    BypassCtrl op2BypassCtrl;
    RdCtrl rdCtrl;
    logic isStore;
    logic isLoad;
  } DecodeStagePipeReg;

  // EX/MEM register
  typedef struct packed {
    BasicData pc;
    BasicData aluResult; // also the memory address
    BasicData wData;
    MemAccessWidth memAccessWidth;
    RdCtrl rdCtrl;
    logic isStore;
    logic isLoad;
    logic isLoadUnsigned;
  } MemoryAccessStagePipeReg;

  typedef struct packed {
    logic taken;
    BasicData target;
  } RedirectReq;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import PipelineTypes::*; (
  input AluCode aluCode,
  input BasicData op1,
  input BasicData op2,
  output BasicData aluResult,
  output logic isBranch,
  output logic brTaken,
  output MemAccessWidth memAccessWidth,
  output logic isLoadUnsigned
);

  logic [4:0] shamt;
  logic signedLt;
  logic unsignedLt;
  logic isEqual;

  assign shamt = op2[4:0];
  assign signedLt = $signed(op1) < $signed(op2);
  assign unsignedLt = op1 < op2;
  assign isEqual = op1 == op2;

  always_comb begin
    case (aluCode)
      ADD: aluResult = op1 + op2;
      SUB: aluResult = op1 - op2;
      SLL: aluResult = op1 << shamt;
      SLT: aluResult = {31'd0, signedLt};
      SLTU: aluResult = {31'd0, unsignedLt};
      XOR: aluResult = op1 ^ op2;
      SRL: aluResult = op1 >> shamt;
      SRA: aluResult = BasicData'($signed(op1) >>> shamt);
      OR: aluResult = op1 | op2;
      AND: aluResult = op1 & op2;
      LUI: aluResult = op2;
      JAL,
      JALR: aluResult = op1 + op2; // pc + 4 for the link register
      LB, LH, LW, LBU, LHU,
      SB, SH, SW: aluResult = op1 + op2; // effective address
      default: aluResult = '0; // branches write nothing
    endcase
  end

  always_comb begin
    isBranch = 1'b1;
    case (aluCode)
      BEQ: brTaken = isEqual;
      BNE: brTaken = !isEqual;
      BLT: brTaken = signedLt;
      BGE: brTaken = !signedLt;
      BLTU: brTaken = unsignedLt;
      BGEU: brTaken = !unsignedLt;
      JAL,
      JALR: brTaken = 1'b1;
      default: begin
        isBranch = 1'b0;
        brTaken = 1'b0;
      end
    endcase
  end

  // access attributes for the memory stage
  always_comb begin
    memAccessWidth = MEM_WORD;
    isLoadUnsigned = 1'b0;
    case (aluCode)
      LB,
      SB: memAccessWidth = MEM_BYTE;
      LH,
      SH: memAccessWidth = MEM_HALF;
      LBU: begin
        memAccessWidth = MEM_BYTE;
        isLoadUnsigned = 1'b1;
      end
      LHU: begin
        memAccessWidth = MEM_HALF;
        isLoadUnsigned = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/execSwitcher.sv
`timescale 1ns/1ps
`default_nettype none

module execSwitcher import PipelineTypes::*; (
  input BasicData pc,
  input BasicData rs1,
  input BasicData rs2,
  input BasicData imm,
  input AluCtrl aluCtrl,
  output BasicData aluOp1,
  output BasicData aluOp2,
  output BasicData npcOp1,
  output BasicData npcOp2
);

  always_comb begin
    case (aluCtrl.op1Sel)
      OP1_RS1: aluOp1 = rs1;
      OP1_PC: aluOp1 = pc;  // auipc, jal, jalr link
      OP1_ZERO: aluOp1 = '0;
      default: aluOp1 = rs1;
    endcase
  end

  always_comb begin
    case (aluCtrl.op2Sel)
      OP2_RS2: aluOp2 = rs2;
      OP2_IMM: aluOp2 = imm;
      OP2_FOUR: aluOp2 = 32'd4; // link address
      default: aluOp2 = rs2;
    endcase
  end

  // jump target base: jalr is register relative, everything else pc relative
  assign npcOp1 = (aluCtrl.aluCode == JALR) ? rs1 : pc;
  assign npcOp2 = imm;

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import PipelineTypes::*; (
  input logic clk,
  input logic rstN,
  input DecodeStagePipeReg prev,
  input BasicData bypassExData,
  input BasicData bypassMemData,
  output MemoryAccessStagePipeReg nextStage,
  output RedirectReq redirect,
  output BasicData exwData,
  output RdCtrl rdCtrl
);

  BasicData bypassedRs1;
  BasicData bypassedRs2;
  BasicData aluOp1;
  BasicData aluOp2;
  BasicData npcOp1;
  BasicData npcOp2;
  BasicData aluResult;
  logic isBranch;
  logic brTaken;
  MemAccessWidth memAccessWidth;
  logic isLoadUnsigned;
  RedirectReq irregPc;

  assign rdCtrl = prev.rdCtrl; // for hazard detection, same cycle
  assign exwData = nextStage.aluResult;

  // forwarding muxes
  always_comb begin
    case (prev.op1BypassCtrl)
      BYPASS_EXEC: bypassedRs1 = bypassExData;
      BYPASS_MEM: bypassedRs1 = bypassMemData;
      default: bypassedRs1 = prev.rs1Data;
    endcase
  end

  always_comb begin
    case (prev.op2BypassCtrl)
      BYPASS_EXEC: bypassedRs2 = bypassExData;
      BYPASS_MEM: bypassedRs2 = bypassMemData;
      default: bypassedRs2 = prev.rs2Data;
    endcase
  end

  execSwitcher execSwitcherInst (
    .pc(prev.pc),
    .rs1(bypassedRs1),
    .rs2(bypassedRs2),
    .imm(prev.imm),
    .aluCtrl(prev.aluCtrl),
    .aluOp1(aluOp1),
    .aluOp2(aluOp2),
    .npcOp1(npcOp1),
    .npcOp2(npcOp2)
  );

  alu aluInst (
    .aluCode(prev.aluCtrl.aluCode),
    .op1(aluOp1),
    .op2(aluOp2),
    .aluResult(aluResult),
    .isBranch(isBranch),
    .brTaken(brTaken),
    .memAccessWidth(memAccessWidth),
    .isLoadUnsigned(isLoadUnsigned)
  );

  irregPcGen irregPcGenInst (
    .op1(npcOp1),
    .op2(npcOp2),
    .isBranch(isBranch),
    .brTaken(brTaken),
    .irregPc(irregPc)
  );

  // EX/MEM register and redirect
  always_ff @(posedge clk) begin
    if (!rstN) begin
      nextStage <= '0;
      redirect <= '0;
    end else begin
      nextStage.pc <= prev.pc;
      nextStage.aluResult <= aluResult;
      nextStage.wData <= bypassedRs2;  // store data sees forwarding too
      nextStage.memAccessWidth <= memAccessWidth;
      nextStage.rdCtrl <= prev.rdCtrl;
      nextStage.isStore <= prev.isStore;
      nextStage.isLoad <= prev.isLoad;
      nextStage.isLoadUnsigned <= isLoadUnsigned;
      redirect <= irregPc;
    end
  end

endmodule

`default_nettype wire

//--- rtl/irregPcGen.sv
`timescale 1ns/1ps
`default_nettype none

module irregPcGen import PipelineTypes::*; (
  input BasicData op1,
  input BasicData op2,
  input logic isBranch,
  input logic brTaken,
  output RedirectReq irregPc
);

  BasicData targetSum;

  assign targetSum = op1 + op2;

  // jalr wants bit 0 cleared; harmless for branches and jal
  assign irregPc.target = {targetSum[31:1], 1'b0};
  assign irregPc.taken = isBranch & brTaken;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbExecuteStage -f project.f \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/VtbExecuteStage > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
exit 0
